// ==== filelist.f ====
source/lcd_video_pkg.sv
source/lcd_capture_fsm.sv
source/frame_store.sv
source/raster_timer.sv
source/shade_mixer.sv
source/lcd_video_top.sv
testbench/tb_clock_gen.sv
testbench/tb_lcd_video.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the LCD display path testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f filelist.f --top-module tb_lcd_video \
    -Mdir obj_dir -o tb_lcd_video

# the run stops with a non-zero status on failure, the log decides
./obj_dir/tb_lcd_video > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

// ==== source/frame_store.sv ====
/*
 * Four frame banks of LCD column bytes, each with the contrast that was
 * active when it was captured. All banks are read together once per pixel
 * tick so the shade mixer can pick one or blend them.
 */

`timescale 1ns/100ps

module frame_store
    import lcd_video_pkg::*;
(
    input  logic                        clk_sys,
    input  logic                        wr_en,
    input  bank_addr_t                  wr_addr,
    input  bank_idx_t                   wr_bank,
    input  column_t                     wr_column,
    input  contrast_t                   wr_contrast,
    input  logic                        pix_en,
    input  raster_pos_t                 pos,
    output column_t   [bank_count-1:0] rd_columns,
    output contrast_t [bank_count-1:0] rd_contrasts,
    output logic [2:0]                  pos_bit,
    output logic                        in_image_d
);

    bank_addr_t rd_addr;

    // byte row of the image line, then column within it
    assign rd_addr = bank_addr_t'(pos.y[5:3]) * bank_addr_t'(lcd_xsize)
                   + bank_addr_t'(pos.x);

    for (genvar b = 0; b < bank_count; b++)
    begin : g_bank
        column_t mem [bank_depth];
        logic    bank_sel;

        assign bank_sel = wr_en && (wr_bank == bank_idx_t'(b));

        always_ff @(posedge clk_sys)
        begin
            if (bank_sel)
                mem[wr_addr] <= wr_column;
            if (bank_sel && (wr_addr == '0))
                rd_contrasts[b] <= wr_contrast; // once per capture
            if (pix_en)
                rd_columns[b] <= mem[rd_addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // pixel select and window flag follow the read by a tick
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (pix_en)
        begin
            pos_bit    <= pos.y[2:0];
            in_image_d <= pos.in_image;
        end
    end

endmodule

// ==== source/lcd_capture_fsm.sv ====
/*
 * Capture sequencer. After a frame complete pulse it reads the LCD one
 * column byte per step and writes the image into the current write bank.
 * At the end of a sweep the finished bank becomes the read bank.
 */

`timescale 1ns/100ps

module lcd_capture_fsm
    import lcd_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       frame_complete,
    input  column_t    lcd_column,
    input  contrast_t  lcd_contrast,
    output lcd_req_t   lcd_req,
    output logic       capture_busy,
    output logic       wr_en,
    output bank_addr_t wr_addr,
    output bank_idx_t  wr_bank,
    output column_t    wr_column,
    output contrast_t  wr_contrast,
    output bank_idx_t  rd_bank
);

    typedef enum logic [1:0] {st_idle, st_armed, st_capture} state_t;

    state_t     state;
    logic [2:0] step_cnt;
    logic       step;

    assign step = (step_cnt == 3'(step_div - 1));

    // LCD answers in the same cycle, so data goes straight to the bank
    assign wr_en        = (state == st_capture) && step;
    assign wr_addr      = bank_addr_t'(lcd_req.y) * bank_addr_t'(lcd_xsize)
                        + bank_addr_t'(lcd_req.x);
    assign wr_column    = lcd_column;
    assign wr_contrast  = lcd_contrast;
    assign capture_busy = (state != st_idle);

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            state    <= st_idle;
            step_cnt <= '0;
            lcd_req  <= '0;
            wr_bank  <= 2'd1;
            rd_bank  <= 2'd0;
        end
        else
        begin
            step_cnt <= step ? 3'd0 : step_cnt + 3'd1;

            case (state)
                st_idle:
                    if (frame_complete)
                        state <= st_armed;
                st_armed:
                    if (step)
                        state <= st_capture; // sweep starts on next step
                st_capture:
                    if (step)
                    begin
                        lcd_req.x <= lcd_req.x + 7'd1;
                        if (lcd_req.x == 7'(lcd_xsize - 1))
                        begin
                            lcd_req.x <= '0;
                            lcd_req.y <= lcd_req.y + 3'd1;
                            if (lcd_req.y == 3'(lcd_rows - 1))
                            begin
                                // last byte written, hand the bank over
                                state     <= st_idle;
                                lcd_req.y <= '0;
                                rd_bank   <= wr_bank;
                                wr_bank   <= wr_bank + 2'd1;
                            end
                        end
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

// ==== source/lcd_video_pkg.sv ====
/*
 * Shared sizes, raster timing, colours and types for the LCD display path.
 * Every RTL module of the video path takes this package by wildcard import.
 */

package lcd_video_pkg;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] column_t;    // one LCD column byte, bit 0 is top row
    typedef logic [5:0] contrast_t;
    typedef logic [1:0] bank_idx_t;
    typedef logic [9:0] bank_addr_t;
    typedef logic [7:0] intensity_t; // 0 = off colour, 255 = on colour

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [6:0] x;  // column 0..95
        logic [2:0] y;  // byte row 0..7
    } lcd_req_t;

    typedef struct packed {
        logic [6:0] x;
        logic [5:0] y;
        logic       in_image;
    } raster_pos_t;

    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } video_out_t;

    ////////////////////////////////////////////////////////////
    // sizes and raster timing
    ////////////////////////////////////////////////////////////

    localparam int lcd_xsize  = 96;
    localparam int lcd_ysize  = 64;
    localparam int lcd_rows   = 8;    // rows of bytes
    localparam int bank_count = 4;
    localparam int bank_depth = 768;  // 96 columns x 8 byte rows
    localparam int pix_div    = 5;    // clk_sys cycles per pixel tick
    localparam int step_div   = 8;    // clk_sys cycles per capture step

    localparam logic [8:0] h_total       = 9'd407;
    localparam logic [8:0] v_total       = 9'd262;
    localparam logic [8:0] hs_start      = 9'd383;
    localparam logic [8:0] hs_end        = 9'd406;
    localparam logic [8:0] vs_first_line = 9'd1;
    localparam logic [8:0] vs_last_line  = 9'd3;
    localparam logic [8:0] h_start       = 9'd155; // image centred in raster
    localparam logic [8:0] v_start       = 9'd99;

    // sync idle, both blanks active
    localparam video_out_t video_reset =
        '{rgb: '0, hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1};

    ////////////////////////////////////////////////////////////
    // colours and contrast
    ////////////////////////////////////////////////////////////

    localparam rgb_t off_color = '{red: 8'hB7, green: 8'hCA, blue: 8'hB7};
    localparam rgb_t on_color  = '{red: 8'h04, green: 8'h16, blue: 8'h04};

    // per contrast setting: {light level, dark level}
    localparam intensity_t contrast_map [64][2] = '{
        '{8'd0, 8'd4},     '{8'd0, 8'd4},     '{8'd0, 8'd4},     '{8'd0, 8'd4},    // 00
        '{8'd0, 8'd6},     '{8'd0, 8'd11},    '{8'd0, 8'd17},    '{8'd0, 8'd24},   // 04
        '{8'd0, 8'd31},    '{8'd0, 8'd40},    '{8'd0, 8'd48},    '{8'd0, 8'd57},   // 08
        '{8'd0, 8'd67},    '{8'd0, 8'd77},    '{8'd0, 8'd88},    '{8'd0, 8'd99},   // 0c
        '{8'd0, 8'd110},   '{8'd0, 8'd122},   '{8'd0, 8'd133},   '{8'd0, 8'd146},  // 10
        '{8'd0, 8'd158},   '{8'd0, 8'd171},   '{8'd0, 8'd184},   '{8'd0, 8'd198},  // 14
        '{8'd0, 8'd212},   '{8'd0, 8'd226},   '{8'd0, 8'd240},   '{8'd0, 8'd255},  // 18
        '{8'd2, 8'd255},   '{8'd5, 8'd255},   '{8'd10, 8'd255},  '{8'd15, 8'd255}, // 1c
        '{8'd21, 8'd255},  '{8'd27, 8'd255},  '{8'd34, 8'd255},  '{8'd41, 8'd255}, // 20
        '{8'd48, 8'd255},  '{8'd56, 8'd255},  '{8'd64, 8'd255},  '{8'd73, 8'd255}, // 24
        '{8'd81, 8'd255},  '{8'd90, 8'd255},  '{8'd100, 8'd255}, '{8'd109, 8'd255},
        '{8'd119, 8'd255}, '{8'd129, 8'd255}, '{8'd139, 8'd255}, '{8'd149, 8'd255},
        '{8'd160, 8'd255}, '{8'd171, 8'd255}, '{8'd182, 8'd255}, '{8'd193, 8'd255},
        '{8'd204, 8'd255}, '{8'd216, 8'd255}, '{8'd228, 8'd255}, '{8'd240, 8'd255},
        '{8'd240, 8'd255}, '{8'd240, 8'd255}, '{8'd240, 8'd255}, '{8'd240, 8'd255},
        '{8'd240, 8'd255}, '{8'd240, 8'd255}, '{8'd240, 8'd255}, '{8'd240, 8'd255}
    };

endpackage

// ==== source/lcd_video_top.sv ====
/*
 * Display path top level. Connects the capture sequencer, the frame banks,
 * the raster generator and the shade mixer.
 */

`timescale 1ns/100ps

module lcd_video_top
    import lcd_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       frame_complete,
    input  column_t    lcd_column,
    input  contrast_t  lcd_contrast,
    input  logic       blend_mode,
    output lcd_req_t   lcd_req,
    output logic       capture_busy,
    output video_out_t video
);

    logic                       wr_en;
    bank_addr_t                 wr_addr;
    bank_idx_t                  wr_bank;
    column_t                    wr_column;
    contrast_t                  wr_contrast;
    bank_idx_t                  rd_bank;
    logic                       pix_en;
    raster_pos_t                pos;
    video_out_t                 sync_d;
    column_t   [bank_count-1:0] rd_columns;
    contrast_t [bank_count-1:0] rd_contrasts;
    logic [2:0]                 pos_bit;
    logic                       in_image_d;

    lcd_capture_fsm u_capture (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .frame_complete (frame_complete),
        .lcd_column     (lcd_column),
        .lcd_contrast   (lcd_contrast),
        .lcd_req        (lcd_req),
        .capture_busy   (capture_busy),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_bank        (wr_bank),
        .wr_column      (wr_column),
        .wr_contrast    (wr_contrast),
        .rd_bank        (rd_bank)
    );

    frame_store u_store (
        .clk_sys      (clk_sys),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_bank      (wr_bank),
        .wr_column    (wr_column),
        .wr_contrast  (wr_contrast),
        .pix_en       (pix_en),
        .pos          (pos),
        .rd_columns   (rd_columns),
        .rd_contrasts (rd_contrasts),
        .pos_bit      (pos_bit),
        .in_image_d   (in_image_d)
    );

    raster_timer u_raster (
        .clk_sys (clk_sys),
        .reset   (reset),
        .pix_en  (pix_en),
        .pos     (pos),
        .sync_d  (sync_d)
    );

    shade_mixer u_mixer (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .pix_en       (pix_en),
        .pos_bit      (pos_bit),
        .in_image_d   (in_image_d),
        .rd_columns   (rd_columns),
        .rd_contrasts (rd_contrasts),
        .rd_bank      (rd_bank),
        .blend_mode   (blend_mode),
        .sync_d       (sync_d),
        .video        (video)
    );

endmodule

// ==== source/raster_timer.sv ====
/*
 * Raster generator for a 407 x 262 pixel-tick frame with the 96 x 64 LCD
 * image centred in it. Gives the pixel enable, the image position one tick
 * after the counters, and sync and blanking two ticks after the counters.
 */

`timescale 1ns/100ps

module raster_timer
    import lcd_video_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    output logic        pix_en,
    output raster_pos_t pos,
    output video_out_t  sync_d
);

    logic [2:0] div_cnt;
    logic [8:0] hpos;
    logic [8:0] vpos;
    logic [8:0] x_off;
    logic [8:0] y_off;
    logic       h_active;
    logic       v_active;
    video_out_t sync_now;
    video_out_t sync_q1;

    ////////////////////////////////////////////////////////////
    // pixel divider and counters
    ////////////////////////////////////////////////////////////

    assign pix_en = (div_cnt == 3'(pix_div - 1));

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            hpos    <= '0;
            vpos    <= '0;
        end
        else
        begin
            div_cnt <= pix_en ? 3'd0 : div_cnt + 3'd1;

            if (pix_en)
            begin
                hpos <= hpos + 9'd1;
                if (hpos == h_total - 9'd1)
                begin
                    hpos <= '0;
                    vpos <= vpos + 9'd1;
                    if (vpos == v_total - 9'd1)
                        vpos <= '0; // frame wrap
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // window decode from the current counters
    ////////////////////////////////////////////////////////////

    assign x_off    = hpos - h_start;
    assign y_off    = vpos - v_start;
    assign h_active = (hpos >= h_start) && (hpos < h_start + 9'(lcd_xsize));
    assign v_active = (vpos >= v_start) && (vpos < v_start + 9'(lcd_ysize));

    always_comb
    begin
        sync_now        = video_reset;
        sync_now.hs     = (hpos >= hs_start) && (hpos <= hs_end);
        sync_now.vs     = (vpos >= vs_first_line) && (vpos <= vs_last_line);
        sync_now.hblank = !h_active;
        sync_now.vblank = !v_active;
    end

    // position goes to the bank read, sync waits for read + mixer
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pos     <= '0;
            sync_q1 <= video_reset;
            sync_d  <= video_reset;
        end
        else if (pix_en)
        begin
            pos.x        <= x_off[6:0];
            pos.y        <= y_off[5:0];
            pos.in_image <= h_active && v_active;
            sync_q1      <= sync_now;
            sync_d       <= sync_q1;
        end
    end

endmodule

// ==== source/shade_mixer.sv ====
/*
 * Turns the selected LCD bit into an intensity through the contrast table,
 * optionally averages the four most recent frames, and mixes the off and on
 * colours into 8-bit RGB. Output is registered once per pixel tick.
 */

`timescale 1ns/100ps

module shade_mixer
    import lcd_video_pkg::*;
(
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        pix_en,
    input  logic [2:0]                  pos_bit,
    input  logic                        in_image_d,
    input  column_t   [bank_count-1:0] rd_columns,
    input  contrast_t [bank_count-1:0] rd_contrasts,
    input  bank_idx_t                   rd_bank,
    input  logic                        blend_mode,
    input  video_out_t                  sync_d,
    output video_out_t                  video
);

    // dark level for a set bit, light level otherwise
    function automatic intensity_t bank_level(
        input column_t    col,
        input logic [2:0] bit_sel,
        input contrast_t  contrast
    );
        logic dark;
        dark = col[bit_sel];
        return contrast_map[contrast][dark];
    endfunction

    function automatic logic [7:0] mix_channel(
        input intensity_t level,
        input logic [7:0] off_c,
        input logic [7:0] on_c
    );
        logic [15:0] weighted;
        logic [15:0] quotient;
        weighted = 16'(8'hff - level) * 16'(off_c) + 16'(level) * 16'(on_c);
        quotient = weighted / 16'd255; // truncating
        return quotient[7:0];
    endfunction

    logic [9:0] blend_sum;
    intensity_t single_level;
    intensity_t level;
    rgb_t       mixed;

    assign single_level = bank_level(rd_columns[rd_bank], pos_bit, rd_contrasts[rd_bank]);

    // newest bank plus the three before it, modulo 4
    always_comb
    begin
        blend_sum = '0;
        for (int k = 0; k < bank_count; k++)
        begin
            blend_sum = blend_sum + 10'(bank_level(rd_columns[rd_bank - bank_idx_t'(k)],
                                                   pos_bit,
                                                   rd_contrasts[rd_bank - bank_idx_t'(k)]));
        end
    end

    assign level = blend_mode ? blend_sum[9:2] : single_level; // five shades when blending

    assign mixed.red   = mix_channel(level, off_color.red, on_color.red);
    assign mixed.green = mix_channel(level, off_color.green, on_color.green);
    assign mixed.blue  = mix_channel(level, off_color.blue, on_color.blue);

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
            video <= video_reset;
        else if (pix_en)
        begin
            video.rgb    <= in_image_d ? mixed : '0; // black border
            video.hs     <= sync_d.hs;
            video.vs     <= sync_d.vs;
            video.hblank <= sync_d.hblank;
            video.vblank <= sync_d.vblank;
        end
    end

endmodule

// ==== testbench/lcd_video_stimulus.hex ====
// word 0: number of records, then two words per record
// seed[31:16] captures[15:12] blend[8] contrast[5:0], then reads[31:16] lines[15:0]
00000005
// single frame, mid contrast
12341020
03000040
// single frame, low contrast
5a5a100c
03000040
// four captures, blended
0f0f4110
03000040
// back to single mode, top contrast
7777103f
03000040
// four captures, blended, light levels above zero
3c3c411c
03000040

// ==== testbench/tb_clock_gen.sv ====
/*
 * Clock and reset source for the display path testbench.
 * 40 ns clock, reset held high for the first 16 rising edges.
 */

`timescale 1ns/100ps

module tb_clock_gen
(
    output logic clk_sys,
    output logic reset
);

    initial
    begin
        clk_sys = 1'b0;
        forever
            #20 clk_sys = ~clk_sys; // half of the 40 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (16)
            @(posedge clk_sys);
        #1;
        reset = 1'b0; // released just after the edge, like every other input
    end

endmodule

// ==== testbench/tb_lcd_video.sv ====
/*
 * Testbench for the LCD display path. Reads test records from the stimulus
 * file, plays an LCD model with seeded images, checks the capture sweep,
 * the raster timing and every image pixel against the colour rules.
 * Run through filelist.f with tb_lcd_video as top.
 */

`timescale 1ns/100ps

module tb_lcd_video
    import lcd_video_pkg::*;
();

    logic        clk_sys;
    logic        reset;
    logic        frame_complete;
    column_t     lcd_column;
    contrast_t   lcd_contrast;
    logic        blend_mode;
    lcd_req_t    lcd_req;
    logic        capture_busy;
    video_out_t  video;

    logic [31:0] stim [0:32];
    int          record_count = 0;
    integer      seed;

    // LCD image and the model of the four banks
    column_t     lcd_image [bank_depth];
    bank_addr_t  lcd_addr;
    column_t     bank_img [bank_count][bank_depth];
    contrast_t   bank_con [bank_count];
    bank_idx_t   model_wr;
    bank_idx_t   model_rd;
    logic        blend_now;

    tb_clock_gen u_clock_gen (
        .clk_sys (clk_sys),
        .reset   (reset)
    );

    lcd_video_top u_lcd_video_top (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .frame_complete (frame_complete),
        .lcd_column     (lcd_column),
        .lcd_contrast   (lcd_contrast),
        .blend_mode     (blend_mode),
        .lcd_req        (lcd_req),
        .capture_busy   (capture_busy),
        .video          (video)
    );

    // LCD answers in the same cycle
    assign lcd_addr   = bank_addr_t'(lcd_req.y) * bank_addr_t'(lcd_xsize)
                      + bank_addr_t'(lcd_req.x);
    assign lcd_column = lcd_image[lcd_addr];

    ////////////////////////////////////////////////////////////
    // reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected)
            stop_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_req(input string name, input lcd_req_t expected,
                             input lcd_req_t actual);
        if (actual !== expected)
            stop_run($sformatf("ERR %s expected x=%0d y=%0d actual x=%0d y=%0d", name,
                               expected.x, expected.y, actual.x, actual.y));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_run($sformatf("ERR %s expected %b actual %b", name, expected, actual));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
            stop_run($sformatf("ERR %s expected %0d actual %0d", name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // expected colour from the shading rules
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] shade_channel(input int level, input logic [7:0] off_c,
                                                 input logic [7:0] on_c);
        return 8'(((255 - level) * int'(off_c) + level * int'(on_c)) / 255);
    endfunction

    function automatic rgb_t expected_color(input int x, input int y);
        bank_addr_t addr;
        logic [2:0] row_bit;
        bank_idx_t  b;
        int         sum;
        int         level;
        rgb_t       c;
        addr    = bank_addr_t'((y / 8) * lcd_xsize + x); // eight image lines per byte
        row_bit = 3'(y % 8);
        sum     = 0;
        for (int k = 0; k < bank_count; k++)
        begin
            b   = model_rd - bank_idx_t'(k);
            sum = sum + int'(contrast_map[bank_con[b]][bank_img[b][addr][row_bit]]);
        end
        if (blend_now)
            level = sum / 4;
        else
            level = int'(contrast_map[bank_con[model_rd]][bank_img[model_rd][addr][row_bit]]);
        c.red   = shade_channel(level, off_color.red, on_color.red);
        c.green = shade_channel(level, off_color.green, on_color.green);
        c.blue  = shade_channel(level, off_color.blue, on_color.blue);
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // raster monitor
    ////////////////////////////////////////////////////////////

    // video value of the next pixel tick, stable at the falling edge
    task automatic next_tick(output video_out_t v);
        @(negedge clk_sys);
        while (!u_lcd_video_top.pix_en)
            @(negedge clk_sys);
        v = video;
    endtask

    task automatic check_raster();
        video_out_t prev;
        video_out_t cur;
        int         ticks;
        int         vs_ticks;
        int         vact_ticks;
        int         act_ticks;
        int         hs_gap;
        int         hs_lines;
        int         line_act;
        logic       hs_seen;
        next_tick(cur);
        do
        begin
            prev = cur;
            next_tick(cur);
        end
        while (!(cur.vs && !prev.vs));
        ticks      = 0;
        vs_ticks   = 0;
        vact_ticks = 0;
        act_ticks  = 0;
        hs_gap     = 0;
        hs_lines   = 0;
        line_act   = 0;
        hs_seen    = 1'b0;
        do
        begin
            ticks++;
            hs_gap++;
            if (cur.vs)
                vs_ticks++;
            if (!cur.vblank)
                vact_ticks++;
            if (!cur.vblank && !cur.hblank)
            begin
                act_ticks++;
                line_act++;
            end
            prev = cur;
            next_tick(cur);
            if (cur.hs && !prev.hs)
            begin
                if (hs_seen) // first gap starts mid line
                    check_count("raster line length", int'(h_total), hs_gap);
                if (line_act != 0)
                    check_count("raster line width", lcd_xsize, line_act);
                hs_gap   = 0;
                line_act = 0;
                hs_seen  = 1'b1;
                hs_lines++;
            end
        end
        while (!(cur.vs && !prev.vs));
        check_count("raster frame length", int'(h_total) * int'(v_total), ticks);
        check_count("raster hs lines", int'(v_total), hs_lines);
        check_count("raster vs ticks", 3 * int'(h_total), vs_ticks);
        check_count("raster image lines", lcd_ysize * int'(h_total), vact_ticks);
        check_count("raster image pixels", lcd_xsize * lcd_ysize, act_ticks);
    endtask

    // every pixel of the frame after the next vblank end
    task automatic check_frame(input string name, input int exp_lines);
        video_out_t prev;
        video_out_t cur;
        int         x;
        int         y;
        next_tick(cur);
        do
        begin
            prev = cur;
            next_tick(cur);
        end
        while (!(prev.vblank && !cur.vblank));
        x = 0;
        y = 0;
        while (!cur.vblank)
        begin
            if (!cur.hblank)
            begin
                if (x >= lcd_xsize || y >= lcd_ysize)
                    stop_run($sformatf("%s: unblanked pixel outside the 96 x 64 image", name));
                check_rgb($sformatf("%s pixel x=%0d y=%0d", name, x, y),
                          expected_color(x, y), cur.rgb);
                x++;
            end
            else
            begin
                check_rgb({name, " border"}, '0, cur.rgb);
                if (x != 0)
                begin
                    check_count({name, " line width"}, lcd_xsize, x);
                    x = 0;
                    y++;
                end
            end
            next_tick(cur);
        end
        check_count({name, " image lines"}, exp_lines, y);
    endtask

    ////////////////////////////////////////////////////////////
    // capture of one new LCD image
    ////////////////////////////////////////////////////////////

    task automatic run_capture(input string name, input contrast_t contrast,
                               input int exp_reads);
        lcd_req_t prev_req;
        lcd_req_t exp_req;
        int       reads;
        int       cycles;
        logic     pulsed_again;
        @(posedge clk_sys);
        #1;
        for (int i = 0; i < bank_depth; i++)
            lcd_image[bank_addr_t'(i)] = column_t'($random(seed));
        lcd_contrast   = contrast;
        frame_complete = 1'b1;
        @(posedge clk_sys);
        #1;
        frame_complete = 1'b0;
        @(negedge clk_sys);
        check_bit({name, " busy after pulse"}, 1'b1, capture_busy);
        check_req({name, " first request"}, '0, lcd_req);
        prev_req     = lcd_req;
        reads        = 1;
        cycles       = 2;
        pulsed_again = 1'b0;
        while (capture_busy)
        begin
            if (lcd_req != prev_req)
            begin
                exp_req.x = 7'(reads % lcd_xsize); // x-major sweep
                exp_req.y = 3'(reads / lcd_xsize);
                check_req($sformatf("%s request %0d", name, reads), exp_req, lcd_req);
                prev_req = lcd_req;
                reads++;
            end
            if (!pulsed_again && reads == bank_depth / 2)
            begin
                @(posedge clk_sys);
                #1;
                frame_complete = 1'b1; // halfway pulse, has to be absorbed
                @(posedge clk_sys);
                #1;
                frame_complete = 1'b0;
                pulsed_again   = 1'b1;
                cycles         = cycles + 2;
            end
            @(negedge clk_sys);
            cycles++;
            if (cycles > (bank_depth + 2) * step_div)
                stop_run($sformatf("%s: capture still busy after 770 steps", name));
        end
        check_count({name, " distinct requests"}, exp_reads, reads);
        check_req({name, " request after sweep"}, '0, lcd_req);
        repeat (4 * step_div)
            @(negedge clk_sys);
        check_bit({name, " no second sweep"}, 1'b0, capture_busy);

        // the finished bank becomes the read bank
        for (int i = 0; i < bank_depth; i++)
            bank_img[model_wr][bank_addr_t'(i)] = lcd_image[bank_addr_t'(i)];
        bank_con[model_wr] = contrast;
        model_rd = model_wr;
        model_wr = model_wr + 2'd1;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        logic [31:0] w0;
        logic [31:0] w1;
        string       name;
        frame_complete = 1'b0;
        lcd_contrast   = '0;
        blend_mode     = 1'b0;
        blend_now      = 1'b0;
        seed           = 32'h583a;
        model_wr       = 2'd1;
        model_rd       = 2'd0;
        for (int i = 0; i < bank_depth; i++)
            lcd_image[bank_addr_t'(i)] = '0;
        $readmemh("testbench/lcd_video_stimulus.hex", stim);
        record_count = int'(stim[0]);
        if (record_count < 1 || record_count > 16)
            stop_run("stimulus file holds no usable record count");

        repeat (4)
            @(negedge clk_sys);
        check_bit("reset hs", 1'b0, video.hs);
        check_bit("reset vs", 1'b0, video.vs);
        check_bit("reset hblank", 1'b1, video.hblank);
        check_bit("reset vblank", 1'b1, video.vblank);
        check_rgb("reset rgb", '0, video.rgb);
        check_req("reset request", '0, lcd_req);
        check_bit("reset busy", 1'b0, capture_busy);
        wait (!reset);

        check_raster();

        for (int r = 0; r < record_count; r++)
        begin
            w0   = stim[1 + 2 * r];
            w1   = stim[2 + 2 * r];
            name = $sformatf("record %0d", r);
            seed = seed ^ {16'h0, w0[31:16]};
            @(posedge clk_sys);
            #1;
            blend_mode = w0[8];
            // contrast steps by 3 between captures of one record
            for (int c = 0; c < int'(w0[15:12]); c++)
                run_capture($sformatf("%s capture %0d", name, c),
                            contrast_t'(int'(w0[5:0]) + 3 * c), int'(w1[31:16]));
            blend_now = w0[8];
            check_frame(name, int'(w1[15:0]));
        end

        $display("STATUS: PASS");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        wait (record_count > 0);
        // six frames per record on top of the reset time
        limit = record_count * 6 * int'(h_total) * int'(v_total) * pix_div + 16;
        repeat (limit)
            @(posedge clk_sys);
        stop_run("watchdog: the tests did not finish in the allowed time");
    end

endmodule
